/* design/laneExPkg.sv */
// Lane execute shared types
package laneExPkg;

	localparam int regWidth = 64;
	localparam int regIdWidth = 6;
	localparam int regAddrWidth = 5;
	localparam int regCount = 1 << regAddrWidth;
	localparam logic [regIdWidth-1:0] zeroRegId = 6'd63; // Also stands for ids 32..62

	// Major micro-op codes
	typedef enum logic [5:0] {
		opNop = 6'h00,
		opInvop = 6'h01,
		opMovIr = 6'h02,
		opConvRr = 6'h03,
		opShad3 = 6'h04,
		opShld3 = 6'h05,
		opShadq3 = 6'h06,
		opShldq3 = 6'h07,
		opOpIxs = 6'h08,
		opOpIxt = 6'h09,
		opAlu3 = 6'h0a, // Completed by another lane
		opMul3 = 6'h0b,
		opFpu3 = 6'h0c
	} ucmdOp;

	// Predicate condition
	typedef enum logic [1:0] {
		ccAlways = 2'b00,
		ccNever = 2'b01,
		ccTrue = 2'b10, // Runs when T set
		ccFalse = 2'b11 // Runs when T clear
	} condCode;

	// Immediate load forms
	typedef enum logic [3:0] {
		subLdi = 4'h0,
		subLdish8 = 4'h1,
		subLdish16 = 4'h2,
		subLdish32 = 4'h3
	} movIrSub;

	typedef enum logic [2:0] {
		extSignByte = 3'd0,
		extZeroByte = 3'd1,
		extSignWord = 3'd2,
		extZeroWord = 3'd3,
		extSignLong = 3'd4,
		extZeroLong = 3'd5,
		extPass = 3'd6,
		extNot = 3'd7
	} extSub;

	typedef enum logic [5:0] {
		ixsNop = 6'h00,
		ixsMovt = 6'h01,
		ixsMovnt = 6'h02
	} ixsSub;

	typedef enum logic [5:0] {
		ixtNop = 6'h00,
		ixtSleep = 6'h01,
		ixtBreak = 6'h02
	} ixtSub;

	// Sticky fault reasons
	typedef enum logic [2:0] {
		faultNone = 3'd0,
		faultInvop = 3'd1,
		faultMovIr = 3'd2,
		faultIxs = 3'd3,
		faultIxt = 3'd4,
		faultBreak = 3'd5,
		faultUcmd = 3'd6
	} faultKind;

	typedef struct packed {
		condCode cond;
		ucmdOp cmd;
		logic [5:0] ixt; // Sub-op whose meaning depends on cmd
		logic [regIdWidth-1:0] idRs;
		logic [regIdWidth-1:0] idRt;
		logic [regIdWidth-1:0] idRm; // Destination
		logic [32:0] imm; // Bit 32 is the LDI sign
	} microOp;

	typedef struct packed {
		logic valid;
		logic [regIdWidth-1:0] id;
		logic [regWidth-1:0] value;
	} wbEntry;

endpackage

/* design/extendUnit.sv */
// Sign and zero extension unit
module extendUnit
	import laneExPkg::*;
(
	input logic [regWidth-1:0] src,
	input extSub sub,
	output logic [regWidth-1:0] result
);

	logic signByte;
	logic signWord;
	logic signLong;

	// Sign bits of the three narrow sizes
	assign signByte = src[7];
	assign signWord = src[15];
	assign signLong = src[31];

	always_comb begin
		case (sub)
			extSignByte: begin
				result = {{(regWidth-8){signByte}}, src[7:0]};
			end
			extZeroByte: begin
				result = {{(regWidth-8){1'b0}}, src[7:0]};
			end
			extSignWord: begin
				result = {{(regWidth-16){signWord}}, src[15:0]};
			end
			extZeroWord: begin
				result = {{(regWidth-16){1'b0}}, src[15:0]};
			end
			extSignLong: begin
				result = {{(regWidth-32){signLong}}, src[31:0]};
			end
			extZeroLong: begin
				result = {{(regWidth-32){1'b0}}, src[31:0]};
			end
			extPass: begin
				result = src;
			end
			extNot: begin
				result = ~src; // Bitwise complement
			end
			default: begin
				result = src;
			end
		endcase
	end

endmodule

/* design/shiftUnit.sv */
// Signed-amount barrel shifter
module shiftUnit
	import laneExPkg::*;
(
	input logic [regWidth-1:0] src,
	input logic [7:0] amount, // Positive shifts left and negative right
	input logic arith,
	input logic wide,
	output logic [regWidth-1:0] result
);

	logic [regWidth-1:0] operand;
	logic [regWidth-1:0] fill;
	logic [regWidth-1:0] shifted;
	logic [7:0] negAmount;
	logic [7:0] limit;
	logic narrowSign;

	// Narrow case works on a sign or zero extended low word
	assign narrowSign = arith & src[31];
	assign operand = wide ? src : {{(regWidth-32){narrowSign}}, src[31:0]};
	assign fill = arith ? {regWidth{operand[regWidth-1]}} : '0;

	assign negAmount = -amount; // 1..128 for a right shift
	assign limit = wide ? 8'd64 : 8'd32;

	always_comb begin
		if (!amount[7]) begin
			// Left shift gives zero at or past the width
			if (amount >= limit) begin
				shifted = '0;
			end else begin
				shifted = operand << amount[5:0];
			end
		end else begin
			// Right shift saturates to all fill bits
			if (negAmount >= limit) begin
				shifted = fill;
			end else if (arith) begin
				shifted = $signed(operand) >>> negAmount[5:0];
			end else begin
				shifted = operand >> negAmount[5:0];
			end
		end
	end

	// Upper half left clear for 32-bit ops
	assign result = wide ? shifted : {{(regWidth-32){1'b0}}, shifted[31:0]};

endmodule

/* design/laneRegFile.sv */
// Lane register file with write bypass
module laneRegFile
	import laneExPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [regIdWidth-1:0] idRs,
	input logic [regIdWidth-1:0] idRt,
	input logic [regIdWidth-1:0] idRm,
	output logic [regWidth-1:0] valRs,
	output logic [regWidth-1:0] valRt,
	output logic [regWidth-1:0] valRm,
	input wbEntry write
);

	logic [regWidth-1:0] regs [regCount];

	// Ids past the array act as the zero register
	function automatic logic [regWidth-1:0] readPort(input logic [regIdWidth-1:0] id);
		if (id >= regCount) begin
			return '0;
		end
		if (write.valid && (write.id == id)) begin
			return write.value; // Bypass the pending write
		end
		return regs[id[regAddrWidth-1:0]];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (write.valid && (write.id < regCount)) begin
			regs[write.id[regAddrWidth-1:0]] <= write.value;
		end
	end

	always_comb begin
		valRs = readPort(idRs);
		valRt = readPort(idRt);
		valRm = readPort(idRm);
	end

endmodule

/* design/laneExStage.sv */
// Secondary lane first execute stage
module laneExStage
	import laneExPkg::*;
(
	input logic clock,
	input logic reset,
	input microOp op,
	input logic [regWidth-1:0] valRs,
	input logic [regWidth-1:0] valRt,
	input logic [regWidth-1:0] valRm,
	input logic flush,
	input logic srT,
	output wbEntry result,
	output logic stall,
	output logic [regIdWidth-1:0] heldId,
	output faultKind fault
);

	logic opEnable;
	ucmdOp cmd;
	movIrSub irSub;
	extSub cnvSub;
	ixsSub sSub;
	ixtSub tSub;
	logic shiftArith;
	logic shiftWide;
	logic [regWidth-1:0] extValue;
	logic [regWidth-1:0] shiftValue;
	faultKind nextFault;
	faultKind faultReg;

	// Predicate gate
	always_comb begin
		if (flush) begin
			opEnable = 1'b0;
		end else begin
			case (op.cond)
				ccAlways: opEnable = 1'b1;
				ccNever: opEnable = 1'b0;
				ccTrue: opEnable = srT;
				ccFalse: opEnable = !srT;
			endcase
		end
	end

	assign cmd = opEnable ? op.cmd : opNop; // Cancelled op becomes a NOP

	// Sub-op views of ixt
	assign irSub = movIrSub'(op.ixt[3:0]);
	assign cnvSub = extSub'(op.ixt[2:0]);
	assign sSub = ixsSub'(op.ixt);
	assign tSub = ixtSub'(op.ixt);

	assign shiftArith = (cmd == opShad3) || (cmd == opShadq3);
	assign shiftWide = (cmd == opShadq3) || (cmd == opShldq3);

	extendUnit extendUnit_inst (
		.src(valRs),
		.sub(cnvSub),
		.result(extValue)
	);

	shiftUnit shiftUnit_inst (
		.src(valRs),
		.amount(valRt[7:0]),
		.arith(shiftArith),
		.wide(shiftWide),
		.result(shiftValue)
	);

	always_comb begin
		result.valid = 1'b0;
		result.id = op.idRm;
		result.value = valRm; // Idle value carries Rm for the store path
		heldId = zeroRegId;
		nextFault = faultNone;

		case (cmd)
			opNop: begin
			end
			opInvop: nextFault = faultInvop;
			opMovIr: begin
				result.valid = 1'b1;
				case (irSub)
					subLdi: result.value = {{(regWidth-32){op.imm[32]}}, op.imm[31:0]};
					subLdish8: result.value = {valRs[regWidth-9:0], op.imm[7:0]};
					subLdish16: result.value = {valRs[regWidth-17:0], op.imm[15:0]};
					subLdish32: result.value = {valRs[regWidth-33:0], op.imm[31:0]};
					default: begin
						result.valid = 1'b0;
						nextFault = faultMovIr;
					end
				endcase
			end
			opConvRr: begin
				result.valid = 1'b1;
				result.value = extValue;
			end
			opShad3: begin
				result.valid = 1'b1;
				result.value = {{(regWidth-32){shiftValue[31]}}, shiftValue[31:0]};
			end
			opShld3: begin
				result.valid = 1'b1;
				result.value = {{(regWidth-32){1'b0}}, shiftValue[31:0]};
			end
			opShadq3, opShldq3: begin
				result.valid = 1'b1;
				result.value = shiftValue;
			end
			opOpIxs: begin
				case (sSub)
					ixsNop: begin
					end
					ixsMovt: begin
						result.valid = 1'b1;
						result.value = {{(regWidth-1){1'b0}}, srT};
					end
					ixsMovnt: begin
						result.valid = 1'b1;
						result.value = {{(regWidth-1){1'b0}}, !srT};
					end
					default: nextFault = faultIxs;
				endcase
			end
			opOpIxt: begin
				case (tSub)
					ixtNop, ixtSleep: begin // Sleep is a no-op in this lane
					end
					ixtBreak: nextFault = faultBreak;
					default: nextFault = faultIxt;
				endcase
			end
			opAlu3, opMul3, opFpu3: begin
				heldId = op.idRm; // Result comes from another lane
			end
			default: nextFault = faultUcmd;
		endcase
	end

	assign stall = (nextFault != faultNone);

	// First fault sticks until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			faultReg <= faultNone;
		end else if (faultReg == faultNone) begin
			faultReg <= nextFault;
		end
	end

	assign fault = faultReg;

endmodule

/* design/laneExTop.sv */
// Secondary lane execute top
module laneExTop
	import laneExPkg::*;
(
	input logic clock,
	input logic reset,
	input microOp op,
	input logic flush,
	input logic srT,
	output wbEntry wb,
	output logic stall,
	output logic [regIdWidth-1:0] heldId,
	output faultKind fault
);

	logic [regWidth-1:0] valRs;
	logic [regWidth-1:0] valRt;
	logic [regWidth-1:0] valRm;
	wbEntry result;

	laneRegFile laneRegFile_inst (
		.clock(clock),
		.reset(reset),
		.idRs(op.idRs),
		.idRt(op.idRt),
		.idRm(op.idRm),
		.valRs(valRs),
		.valRt(valRt),
		.valRm(valRm),
		.write(wb)
	);

	laneExStage laneExStage_inst (
		.clock(clock),
		.reset(reset),
		.op(op),
		.valRs(valRs),
		.valRt(valRt),
		.valRm(valRm),
		.flush(flush),
		.srT(srT),
		.result(result),
		.stall(stall),
		.heldId(heldId),
		.fault(fault)
	);

	// Writeback register
	always_ff @(posedge clock) begin
		wb.id <= result.id;
		wb.value <= result.value;
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= result.valid;
		end
	end

endmodule

/* tb/laneExChecks_sva.sv */
// Lane execute assertions
module laneExChecks
	import laneExPkg::*;
(
	input logic clock,
	input logic reset,
	input microOp op,
	input logic flush,
	input logic srT,
	input wbEntry wb,
	input wbEntry result,
	input logic stall,
	input logic [regIdWidth-1:0] heldId,
	input faultKind fault
);

	logic cancelled;

	// Op cancelled by flush or by its condition
	assign cancelled = flush || (op.cond == ccNever) || ((op.cond == ccTrue) && !srT)
		|| ((op.cond == ccFalse) && srT);

	wbAfterReset: assert property (@(posedge clock) reset |=> !wb.valid)
		else $error("wb.valid set in the cycle after reset");

	faultSticky: assert property (@(posedge clock) disable iff (reset)
		(fault != faultNone) |=> (fault != faultNone))
		else $error("fault went back to none without reset");

	stallNoResult: assert property (@(posedge clock) !(stall && result.valid))
		else $error("stall raised together with a valid stage result");

	cancelNoHeld: assert property (@(posedge clock) cancelled |-> (heldId == zeroRegId))
		else $error("heldId reported for a cancelled op");

endmodule

bind laneExTop laneExChecks laneExChecks_inst (
	.clock(clock),
	.reset(reset),
	.op(op),
	.flush(flush),
	.srT(srT),
	.wb(wb),
	.result(result),
	.stall(stall),
	.heldId(heldId),
	.fault(fault)
);

/* tb/laneExTb.sv */
// Lane execute testbench
module laneExTb
	import laneExPkg::*;
();

	logic clock;
	logic reset;
	microOp op;
	logic flush;
	logic srT;
	wbEntry wb;
	logic stall;
	logic [regIdWidth-1:0] heldId;
	faultKind fault;

	logic [31:0] rngState;
	int errors;
	int opCount;
	logic [regWidth-1:0] modelRegs [32];
	faultKind modelFault; // First fault of the run
	wbEntry expWb; // From the op just driven
	wbEntry pendWb; // Due on wb at this negedge
	logic expStall;
	logic [regIdWidth-1:0] expHeld;
	logic [regIdWidth-1:0] lastId;

	laneExTop laneExTop_inst (
		.clock(clock),
		.reset(reset),
		.op(op),
		.flush(flush),
		.srT(srT),
		.wb(wb),
		.stall(stall),
		.heldId(heldId),
		.fault(fault)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState ^ (rngState >> 15); // Fold high bits down
	endfunction

	function automatic logic [regIdWidth-1:0] pickId();
		logic [31:0] r;
		r = nextRandom();
		if (r[3:0] == 0) begin
			return 6'd32 + 6'(r[8:4]); // Outside the file
		end
		return 6'(r[6:4]); // Small set so ops depend on each other
	endfunction

	function automatic logic [regWidth-1:0] readModel(input logic [regIdWidth-1:0] id);
		return (id < 32) ? modelRegs[id[4:0]] : '0;
	endfunction

	function automatic logic [regWidth-1:0] extendExpected(input logic [63:0] s,
		input logic [2:0] sub);
		case (sub)
			3'd0: return 64'($signed(s[7:0]));
			3'd1: return 64'(s[7:0]);
			3'd2: return 64'($signed(s[15:0]));
			3'd3: return 64'(s[15:0]);
			3'd4: return 64'($signed(s[31:0]));
			3'd5: return 64'(s[31:0]);
			3'd6: return s;
			default: return ~s;
		endcase
	endfunction

	// One bit per step, so large amounts saturate by themselves
	function automatic logic [regWidth-1:0] shiftExpected(input logic [63:0] src,
		input logic [7:0] amt, input logic arith, input logic wide);
		int count;
		logic [63:0] v;
		logic [31:0] w;
		count = int'($signed(amt));
		v = src;
		w = src[31:0];
		for (int i = 0; i < count; i++) begin
			v = v << 1;
			w = w << 1;
		end
		for (int i = 0; i < -count; i++) begin
			v = {arith & v[63], v[63:1]};
			w = {arith & w[31], w[31:1]};
		end
		return wide ? v : {32'b0, w};
	endfunction

	task automatic predictOp(input microOp o, input logic fl, input logic t);
		logic enabled;
		logic [63:0] rs;
		logic [63:0] rt;
		logic [63:0] sh;
		faultKind f;
		enabled = !fl && ((o.cond == ccAlways) || ((o.cond == ccTrue) && t)
			|| ((o.cond == ccFalse) && !t));
		rs = readModel(o.idRs);
		rt = readModel(o.idRt);
		sh = shiftExpected(rs, rt[7:0], o.cmd inside {opShad3, opShadq3},
			o.cmd inside {opShadq3, opShldq3});
		f = faultNone;
		expWb = '{valid: 1'b0, id: o.idRm, value: '0};
		expHeld = zeroRegId;
		if (enabled) begin
			expWb.valid = 1'b1;
			case (o.cmd)
				opMovIr: begin
					case (o.ixt[3:0])
						4'h0: expWb.value = 64'($signed(o.imm));
						4'h1: expWb.value = (rs << 8) | 64'(o.imm[7:0]);
						4'h2: expWb.value = (rs << 16) | 64'(o.imm[15:0]);
						4'h3: expWb.value = (rs << 32) | 64'(o.imm[31:0]);
						default: f = faultMovIr;
					endcase
				end
				opConvRr: expWb.value = extendExpected(rs, o.ixt[2:0]);
				opShad3: expWb.value = 64'($signed(sh[31:0]));
				opShld3: expWb.value = 64'(sh[31:0]);
				opShadq3, opShldq3: expWb.value = sh;
				opOpIxs: begin
					if (o.ixt == ixsMovt || o.ixt == ixsMovnt) begin
						expWb.value = 64'(t ^ (o.ixt == ixsMovnt));
					end else begin
						expWb.valid = 1'b0;
						f = (o.ixt == ixsNop) ? faultNone : faultIxs;
					end
				end
				opOpIxt: begin
					expWb.valid = 1'b0;
					f = (o.ixt == ixtBreak) ? faultBreak : (o.ixt > 1) ? faultIxt : faultNone;
				end
				opAlu3, opMul3, opFpu3: begin
					expWb.valid = 1'b0;
					expHeld = o.idRm;
				end
				opNop: expWb.valid = 1'b0;
				opInvop: f = faultInvop;
				default: f = faultUcmd;
			endcase
		end
		if (f != faultNone) begin
			expWb.valid = 1'b0;
		end
		expStall = (f != faultNone);
		if (modelFault == faultNone) begin
			modelFault = f;
		end
	endtask

	task automatic driveRandomOp();
		microOp o;
		logic [31:0] r;
		logic [31:0] pick;
		r = nextRandom();
		pick = nextRandom() % 32;
		o.cond = r[0] ? ccAlways : condCode'(r[2:1]);
		o.idRs = (r[4:3] == 0) ? lastId : pickId();
		o.idRt = pickId();
		o.idRm = pickId();
		o.imm = {r[5], nextRandom()};
		o.ixt = 6'(nextRandom() % 4);
		o.cmd = opNop;
		if (pick < 6) begin
			o.cmd = opMovIr;
			if (r[9:6] == 0) begin
				o.ixt = 6'h9; // Bad load form
			end
			if (r[11:10] == 0) begin
				o.imm = 33'(int'(nextRandom() % 161) - 80); // Amounts near the widths
			end
		end else if (pick < 10) begin
			o.cmd = opConvRr;
			o.ixt = 6'(nextRandom() % 8);
		end else if (pick < 18) begin
			o.cmd = ucmdOp'(opShad3 + r[13:12]);
		end else if (pick < 21) begin
			o.cmd = opOpIxs;
		end else if (pick < 23) begin
			o.cmd = opOpIxt;
		end else if (pick < 29) begin
			o.cmd = ucmdOp'(opAlu3 + 6'(pick % 3));
		end else if (pick == 30) begin
			o.cmd = opInvop;
		end else if (pick == 31) begin
			o.cmd = ucmdOp'(6'h10 + r[17:14]); // Unhandled code
		end
		op = o;
		flush = (r[20:18] == 0);
		srT = r[21];
		lastId = o.idRm;
		predictOp(o, flush, srT);
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		errors++;
		$display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, expected);
	endtask

	task automatic checkWriteback();
		if (wb.valid !== pendWb.valid) begin
			reportMismatch("wb.valid", 64'(wb.valid), 64'(pendWb.valid));
		end
		if (pendWb.valid && (wb.id !== pendWb.id)) begin
			reportMismatch("wb.id", 64'(wb.id), 64'(pendWb.id));
		end
		if (pendWb.valid && (wb.value !== pendWb.value)) begin
			reportMismatch("wb.value", wb.value, pendWb.value);
		end
		if (fault !== modelFault) begin
			reportMismatch("fault", 64'(fault), 64'(modelFault));
		end
		if (pendWb.valid && (pendWb.id < 32)) begin
			modelRegs[pendWb.id[4:0]] = pendWb.value;
		end
	endtask

	task automatic runOps();
		for (int n = 0; n <= opCount; n++) begin
			checkWriteback();
			if (n < opCount) begin
				driveRandomOp();
			end else begin
				op = '0;
				flush = 1'b0;
				predictOp(op, flush, srT);
			end
			pendWb = expWb;
			#1;
			if (stall !== expStall) begin
				reportMismatch("stall", 64'(stall), 64'(expStall));
			end
			if (heldId !== expHeld) begin
				reportMismatch("heldId", 64'(heldId), 64'(expHeld));
			end
			@(negedge clock);
		end
	endtask

	// Reset held for 8 rising edges
	initial begin
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	initial begin
		int waitCount;
		clock = 1'b0;
		reset = 1'b1;
		op = '0;
		flush = 1'b0;
		srT = 1'b0;
		rngState = 32'h10dce2ee;
		errors = 0;
		opCount = 4000;
		modelFault = faultNone;
		pendWb = '0;
		lastId = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		waitCount = 0;
		while (reset && (waitCount < 40)) begin
			@(negedge clock);
			waitCount++;
		end
		if (reset) begin
			$display("Timeout: reset was never released");
			errors++;
		end else begin
			runOps();
		end
		$display("Ran %0d ops with %0d errors", opCount, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* list.f */
design/laneExPkg.sv
design/extendUnit.sv
design/shiftUnit.sv
design/laneRegFile.sv
design/laneExStage.sv
design/laneExTop.sv
tb/laneExChecks_sva.sv
tb/laneExTb.sv
